//--- fabric_pkg.sv
`default_nettype none

package fabric_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  // One data word from outside
  localparam int DATA_WIDTH = 16;

  // Sequence tag, wraps modulo 16
  localparam int TAG_WIDTH = 4;

  // Tag in the upper bits, data in the lower bits
  localparam int TOKEN_WIDTH = TAG_WIDTH + DATA_WIDTH;

  // One extra bit so a pair sum never overflows
  localparam int SUM_WIDTH = DATA_WIDTH + 1;

  // Default buffer depth of the fabric FIFO
  localparam int FIFO_DEPTH = 4;

  // ------------------------------
  // Types
  // ------------------------------

  typedef logic [DATA_WIDTH-1:0]  data_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;
  typedef logic [TOKEN_WIDTH-1:0] token_t;
  typedef logic [SUM_WIDTH-1:0]   sum_t;

  // Pair adder FSM, one state per token of the pair
  typedef enum logic [0:0] {
    wait_first  = 1'b0,
    wait_second = 1'b1
  } pair_state_t;

endpackage

`default_nettype wire

//--- fabric_ingress.sv
`timescale 1ns/10ps
`default_nettype none

module fabric_ingress
  import fabric_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  // Words from outside
  input  logic   in_valid,
  output logic   in_ready,
  input  data_t  in_data,

  // Tagged tokens towards the FIFO
  output logic   ing_valid,
  input  logic   ing_ready,
  output token_t ing_token
);

  // Tag that the next accepted word receives
  tag_t tag_cnt;

  logic accept;
  logic drain;

  // ------------------------------
  // Handshake
  // ------------------------------

  // Output register leaves this cycle
  assign drain = ing_valid && ing_ready;

  // Register empty or emptied now, so one word per cycle
  assign in_ready = !ing_valid || ing_ready;

  assign accept = in_valid && in_ready;

  // ------------------------------
  // Control state
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ing_valid <= 1'b0;
      tag_cnt   <= '0;
    end else begin
      if (accept) begin
        ing_valid <= 1'b1;
        // Counter wraps on its own at 16
        tag_cnt   <= tag_cnt + 1'b1;
      end else if (drain) begin
        ing_valid <= 1'b0;
      end
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (accept) begin
      // Stamp with the tag current at acceptance
      ing_token <= {tag_cnt, in_data};
    end
  end

endmodule

`default_nettype wire

//--- fabric_fifo_core.sv
`timescale 1ns/10ps
`default_nettype none

module fabric_fifo_core
  import fabric_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic   clk,
  input  logic   rst_n,

  input  logic   in_valid,
  output logic   in_ready,
  input  token_t in_data,

  output logic   out_valid,
  input  logic   out_ready,
  output token_t out_data
);

  // Pointer and counter widths follow the depth
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  token_t mem [DEPTH];

  logic [PTR_WIDTH-1:0] head;   // next slot to write
  logic [PTR_WIDTH-1:0] tail;   // oldest token
  logic [CNT_WIDTH-1:0] count;

  logic full;
  logic push;
  logic pop;

  assign full = (count == CNT_WIDTH'(DEPTH));
  assign pop  = out_valid && out_ready;

  // Write-through when full only with more than one slot
  assign in_ready = (DEPTH > 1) ? (!full || pop) : !full;
  assign push     = in_valid && in_ready;

  assign out_valid = (count != '0);
  assign out_data  = mem[tail];

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[head] <= in_data;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        head <= (head == PTR_WIDTH'(DEPTH - 1)) ? '0 : head + 1'b1;
      end
      if (pop) begin
        tail <= (tail == PTR_WIDTH'(DEPTH - 1)) ? '0 : tail + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- fabric_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module fabric_fifo
  import fabric_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic   clk,
  input  logic   rst_n,

  // Static mode select, change only while the lane is empty
  input  logic   cfg_bypass,

  // Upstream side
  input  logic   in_valid,
  output logic   in_ready,
  input  token_t in_data,

  // Downstream side
  output logic   out_valid,
  input  logic   out_ready,
  output token_t out_data
);

  // Core side of the mux
  logic   core_in_valid;
  logic   core_in_ready;
  token_t core_in_data;
  logic   core_out_valid;
  logic   core_out_ready;
  token_t core_out_data;

  // ------------------------------
  // Mode mux
  // ------------------------------

  always_comb begin
    if (cfg_bypass) begin
      // Zero-latency path, handshake passes straight through
      out_valid      = in_valid;
      out_data       = in_data;
      in_ready       = out_ready;
      // Core sees no traffic in either direction
      core_in_valid  = 1'b0;
      core_in_data   = '0;
      core_out_ready = 1'b0;
    end else begin
      // Buffered path through the core
      core_in_valid  = in_valid;
      core_in_data   = in_data;
      in_ready       = core_in_ready;
      out_valid      = core_out_valid;
      out_data       = core_out_data;
      core_out_ready = out_ready;
    end
  end

  // ------------------------------
  // Buffer
  // ------------------------------

  fabric_fifo_core #(
    .DEPTH (DEPTH)
  ) u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (core_in_valid),
    .in_ready  (core_in_ready),
    .in_data   (core_in_data),
    .out_valid (core_out_valid),
    .out_ready (core_out_ready),
    .out_data  (core_out_data)
  );

endmodule

`default_nettype wire

//--- fabric_pair_adder.sv
`timescale 1ns/10ps
`default_nettype none

module fabric_pair_adder
  import fabric_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  // Tokens from the FIFO
  input  logic   in_valid,
  output logic   in_ready,
  input  token_t in_token,

  // Registered pair result
  output logic   out_valid,
  input  logic   out_ready,
  output sum_t   out_sum,
  output tag_t   out_tag
);

  pair_state_t state;

  // First token of the pair
  data_t held_data;
  tag_t  held_tag;

  data_t tok_data;
  tag_t  tok_tag;
  logic  accept;
  logic  drain;

  assign tok_data = in_token[DATA_WIDTH-1:0];
  assign tok_tag  = in_token[TOKEN_WIDTH-1 -: TAG_WIDTH];

  assign drain = out_valid && out_ready;

  // Stall only when a second token has nowhere to go
  assign in_ready = !((state == wait_second) && out_valid && !out_ready);
  assign accept   = in_valid && in_ready;

  // ------------------------------
  // FSM and result valid
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= wait_first;
      out_valid <= 1'b0;
    end else begin
      case (state)
        wait_first: begin
          if (accept) begin
            state <= wait_second;
          end
          if (drain) begin
            out_valid <= 1'b0;
          end
        end
        wait_second: begin
          if (accept) begin
            state     <= wait_first;
            out_valid <= 1'b1;
          end else if (drain) begin
            out_valid <= 1'b0;
          end
        end
        default: state <= wait_first;
      endcase
    end
  end

  // ------------------------------
  // Holding and result registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (accept && (state == wait_first)) begin
      held_data <= tok_data;
      held_tag  <= tok_tag;
    end
    if (accept && (state == wait_second)) begin
      // Zero-extend both words before the add
      out_sum <= sum_t'(held_data) + sum_t'(tok_data);
      out_tag <= held_tag;
    end
  end

endmodule

`default_nettype wire

//--- fabric_lane.sv
`timescale 1ns/10ps
`default_nettype none

module fabric_lane
  import fabric_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  // Buffer mode, static while tokens are in flight
  input  logic  cfg_bypass,

  // Word stream in
  input  logic  in_valid,
  output logic  in_ready,
  input  data_t in_data,

  // Pair sums out
  output logic  out_valid,
  input  logic  out_ready,
  output sum_t  out_sum,
  output tag_t  out_tag
);

  // Ingress to FIFO
  logic   ing_valid;
  logic   ing_ready;
  token_t ing_token;

  // FIFO to pair adder
  logic   fifo_valid;
  logic   fifo_ready;
  token_t fifo_token;

  // ------------------------------
  // Stages
  // ------------------------------

  fabric_ingress u_ingress (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .ing_valid (ing_valid),
    .ing_ready (ing_ready),
    .ing_token (ing_token)
  );

  fabric_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_bypass (cfg_bypass),
    .in_valid   (ing_valid),
    .in_ready   (ing_ready),
    .in_data    (ing_token),
    .out_valid  (fifo_valid),
    .out_ready  (fifo_ready),
    .out_data   (fifo_token)
  );

  fabric_pair_adder u_pair_adder (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .in_token  (fifo_token),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_sum   (out_sum),
    .out_tag   (out_tag)
  );

endmodule

`default_nettype wire

//--- fabric_lane_props.sv
`timescale 1ns/10ps
`default_nettype none

module fabric_lane_props
  import fabric_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic in_ready,
  input logic out_valid,
  input logic out_ready,
  input sum_t out_sum,
  input tag_t out_tag
);

  // Running total of failed properties, read at the end of the run
  int fail_count = 0;

  // ------------------------------
  // Reset behaviour
  // ------------------------------

  // Result register clears as soon as reset is applied
  out_valid_low_in_reset: assert property (
    @(posedge clk) !rst_n |-> !out_valid
  ) else begin
    $error("out_valid high while reset is applied");
    fail_count++;
  end

  // Ingress register is empty in reset, so the lane offers ready
  in_ready_high_in_reset: assert property (
    @(posedge clk) !rst_n |-> in_ready
  ) else begin
    $error("in_ready low while reset is applied");
    fail_count++;
  end

  // ------------------------------
  // Output handshake
  // ------------------------------

  // Stalled result keeps valid and payload until taken
  out_hold_while_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_sum) && $stable(out_tag))
  ) else begin
    $error("Stalled result changed before out_ready");
    fail_count++;
  end

  // Pairs start on even word counts, so the first tag of a pair is even
  out_tag_even: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> !out_tag[0]
  ) else begin
    $error("Odd out_tag on a valid result");
    fail_count++;
  end

endmodule

// Every lane instance gets the checker
bind fabric_lane fabric_lane_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_sum   (out_sum),
  .out_tag   (out_tag)
);

`default_nettype wire

//--- tb_fabric_lane.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fabric_lane
  import fabric_pkg::*;
();

  // Words per streaming phase
  localparam int N_WORDS     = 100;
  // Enough to fill ingress, FIFO and pair adder with room to spare
  localparam int FULL_WORDS  = 10;
  localparam int TOTAL_WORDS = 3 * N_WORDS + FULL_WORDS;
  // 310 words at up to about 5 cycles each, plus margin
  localparam int MAX_CYCLES  = 2000;

  logic  clk;
  logic  rst_n;
  logic  cfg_bypass;
  logic  in_valid;
  logic  in_ready;
  data_t in_data;
  logic  out_valid;
  logic  out_ready;
  sum_t  out_sum;
  tag_t  out_tag;

  int    seed;
  int    err_cnt;
  int    cycle_cnt;
  int    pair_cnt;
  // Reference model, accepted words in arrival order
  data_t model_q[$];

  // Sink behaviour
  logic  stall_en;
  logic  hold_low;
  logic  next_ready;
  logic  saw_full;

  always #20 clk = ~clk;

  fabric_lane u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_bypass (cfg_bypass),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_sum    (out_sum),
    .out_tag    (out_tag)
  );

  // ------------------------------
  // Sink and monitor
  // ------------------------------

  // Stall decision drawn mid-cycle, applied just after the edge
  always begin
    @(negedge clk);
    if (hold_low) begin
      next_ready = 1'b0;
    end else if (stall_en) begin
      next_ready = (($random(seed) & 3) != 0);
    end else begin
      next_ready = 1'b1;
    end
    @(posedge clk);
    #2;
    out_ready = next_ready;
  end

  // Expected sum is the two oldest words, tag follows the pair count
  task automatic check_pair();
    data_t first;
    data_t second;
    sum_t  exp_sum;
    tag_t  exp_tag;
    if (model_q.size() < 2) begin
      $display("Sum arrived with fewer than two words outstanding");
      err_cnt++;
    end else begin
      first   = model_q.pop_front();
      second  = model_q.pop_front();
      exp_sum = {1'b0, first} + {1'b0, second};
      exp_tag = tag_t'((pair_cnt * 2) % 16);
      assert (out_sum == exp_sum) else begin
        $display("ERROR out_sum expected %h got %h", exp_sum, out_sum);
        err_cnt++;
      end
      assert (out_tag == exp_tag) else begin
        $display("ERROR out_tag expected %h got %h", exp_tag, out_tag);
        err_cnt++;
      end
    end
    pair_cnt++;
  endtask

  // Signals are settled at the falling edge, transfers land on the next rise
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_valid && in_ready) begin
        model_q.push_back(in_data);
      end
      if (hold_low && in_valid && !in_ready) begin
        saw_full = 1'b1;
      end
      if (out_valid && out_ready) begin
        check_pair();
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the lane stopped making progress", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // One word after a random idle gap, valid held until taken
  task automatic send_word(input int max_gap);
    int   gap;
    logic taken;
    gap = (max_gap > 0) ? ({$random(seed)} % (max_gap + 1)) : 0;
    in_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    in_valid = 1'b1;
    in_data  = data_t'($random(seed));
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
  endtask

  task automatic send_words(input int n, input int max_gap);
    repeat (n) begin
      send_word(max_gap);
    end
  endtask

  // Lane is empty once every accepted word has left as part of a sum
  task automatic wait_idle();
    do begin
      @(posedge clk);
      #2;
    end while (model_q.size() != 0);
    repeat (2) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    cfg_bypass = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    seed       = 32'hbd53_bb13;
    err_cnt    = 0;
    cycle_cnt  = 0;
    pair_cnt   = 0;
    stall_en   = 1'b0;
    hold_low   = 1'b0;
    next_ready = 1'b1;
    saw_full   = 1'b0;

    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Buffered, free-flowing sink
    send_words(N_WORDS, 0);
    wait_idle();

    // Buffered with input gaps and output stalls
    stall_en = 1'b1;
    send_words(N_WORDS, 3);
    wait_idle();

    // Sink held off until the lane backs up to the input
    stall_en = 1'b0;
    hold_low = 1'b1;
    fork
      send_words(FULL_WORDS, 0);
      begin
        repeat (30) @(posedge clk);
        #2;
        hold_low = 1'b0;
      end
    join
    wait_idle();
    assert (saw_full) else begin
      $display("in_ready never fell while the sink was held off");
      err_cnt++;
    end

    // Mode change while the lane is empty
    cfg_bypass = 1'b1;
    stall_en   = 1'b1;
    send_words(N_WORDS, 3);
    wait_idle();

    assert (pair_cnt == TOTAL_WORDS / 2) else begin
      $display("Expected %0d sums but saw %0d", TOTAL_WORDS / 2, pair_cnt);
      err_cnt++;
    end

    $display("Error counts: %0d checks, %0d assertions", err_cnt, u_dut.u_props.fail_count);
    if ((err_cnt == 0) && (u_dut.u_props.fail_count == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
fabric_pkg.sv
fabric_ingress.sv
fabric_fifo_core.sv
fabric_fifo.sv
fabric_pair_adder.sv
fabric_lane.sv
fabric_lane_props.sv
tb_fabric_lane.sv
